//--- video_core_pkg.sv
// --------------------
// Addresses are 16-bit word addresses in a 20-bit banked space.
// Region bases and lengths are in words.
// --------------------
package video_core_pkg;

  localparam int MPU_ADDR_W    = 16;
  localparam int MPU_DATA_W    = 16;
  localparam int PAGE_OFFSET_W = 12;
  localparam int BANK_W        = 8;
  localparam int INT_ADDR_W    = BANK_W + PAGE_OFFSET_W;
  localparam int VRAM_ADDR_W   = 16;
  localparam int SCAN_W        = 10;

  localparam logic [INT_ADDR_W-1:0] REG_BASE     = 20'h00000;
  localparam int                    NUM_REGS     = 16;
  localparam logic [INT_ADDR_W-1:0] PAL_BASE     = 20'h00800;
  localparam logic [INT_ADDR_W-1:0] PAL_LEN      = 20'h00200;
  localparam logic [INT_ADDR_W-1:0] VRAM_BASE    = 20'h10000;
  localparam logic [INT_ADDR_W-1:0] VRAM_LEN     = 20'h10000;
  localparam logic [INT_ADDR_W-1:0] LOW_MEM_SIZE = 20'h01000;

  // Three 8-bit colour channels per palette entry
  localparam int PAL_CHANNELS = 3;
  localparam int PAL_ENTRIES  = 256;

  localparam logic [MPU_DATA_W-1:0] UNMAPPED_VALUE = 16'hDEAD;
  localparam logic [MPU_DATA_W-1:0] ID_VALUE       = 16'h4443;

  // Grant bit in SYS_CTRL that gives the MPU the VRAM bus
  localparam int SYS_CTRL_VRAM_ACCESS = 0;

  typedef enum logic [3:0] {
    ID            = 4'd0,
    SYS_CTRL      = 4'd1,
    MEM_BANK      = 4'd2,
    OUTPUT_STATUS = 4'd3,
    SCAN_X        = 4'd4,
    SCAN_Y        = 4'd5
  } reg_index_e;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_REGS,
    REGION_PAL,
    REGION_VRAM
  } region_e;

  // MPU access after banking
  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic [1:0]            be;
    logic [INT_ADDR_W-1:0] addr;
    logic [MPU_DATA_W-1:0] data;
  } mpu_req_t;

  typedef struct packed {
    logic                   en;
    logic                   rd;
    logic                   wr;
    logic [1:0]             be;
    logic [VRAM_ADDR_W-1:0] addr;
    logic [MPU_DATA_W-1:0]  data;
  } vram_bus_t;

  typedef struct packed {
    logic              hsync;
    logic              vsync;
    logic              hblank;
    logic              vblank;
    logic [SCAN_W-1:0] scan_x;
    logic [SCAN_W-1:0] scan_y;
  } disp_status_t;

  // Unsigned offset compare also covers addresses below the base
  function automatic logic in_window(logic [INT_ADDR_W-1:0] addr,
                                     logic [INT_ADDR_W-1:0] base,
                                     logic [INT_ADDR_W-1:0] len);
    logic [INT_ADDR_W-1:0] offset;
    offset = addr - base;
    return offset < len;
  endfunction

endpackage

//--- display_timing.sv
// --------------------
// Counters start at 0 after reset. Sync and blank are active high.
// --------------------
`timescale 1ns/100ps

module display_timing import video_core_pkg::*; #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic         clk,
  input  logic         rst,
  output disp_status_t status
);

  localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT;

  logic [SCAN_W-1:0] h_count;
  logic [SCAN_W-1:0] v_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == SCAN_W'(H_TOTAL - 1)) begin
      h_count <= '0;
      // Vertical steps once per line
      if (v_count == SCAN_W'(V_TOTAL - 1)) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign status.hblank = h_count >= SCAN_W'(H_VISIBLE);
  assign status.vblank = v_count >= SCAN_W'(V_VISIBLE);
  assign status.hsync  = (h_count >= SCAN_W'(H_SYNC_START)) &&
                         (h_count <  SCAN_W'(H_SYNC_START + H_SYNC));
  assign status.vsync  = (v_count >= SCAN_W'(V_SYNC_START)) &&
                         (v_count <  SCAN_W'(V_SYNC_START + V_SYNC));

  // Position reads as 0 outside the visible area
  assign status.scan_x = status.hblank ? '0 : h_count;
  assign status.scan_y = status.vblank ? '0 : v_count;

  a_counters_in_range: assert property (
    @(posedge clk) disable iff (rst)
    (h_count < SCAN_W'(H_TOTAL)) && (v_count < SCAN_W'(V_TOTAL))
  );

endmodule

//--- palette_ram.sv
// --------------------
// Two words per entry. The high byte of an odd word reads 0.
// --------------------
`timescale 1ns/100ps

module palette_ram import video_core_pkg::*; (
  input  logic                  clk,
  input  mpu_req_t              req,
  input  logic                  sel,
  output logic [MPU_DATA_W-1:0] rdata
);

  logic [INT_ADDR_W-1:0]     pal_offset;
  logic [7:0]                entry;
  logic                      odd_word;
  logic [PAL_CHANNELS-1:0]   lane_we;
  logic [PAL_CHANNELS*8-1:0] lane_wdata;
  logic [PAL_CHANNELS*8-1:0] lane_rdata;
  logic                      rd_odd;

  assign pal_offset = req.addr - PAL_BASE;
  assign entry      = pal_offset[8:1];
  assign odd_word   = pal_offset[0];

  // Even word holds channels 0 and 1, odd word holds channel 2
  assign lane_we[0] = sel & req.wr & ~odd_word & req.be[0];
  assign lane_we[1] = sel & req.wr & ~odd_word & req.be[1];
  assign lane_we[2] = sel & req.wr &  odd_word & req.be[0];
  assign lane_wdata = {req.data[7:0], req.data[15:8], req.data[7:0]};

  for (genvar i = 0; i < PAL_CHANNELS; i++) begin : g_lane
    logic [7:0] mem [PAL_ENTRIES];

    always_ff @(posedge clk) begin
      if (lane_we[i]) begin
        mem[entry] <= lane_wdata[i*8 +: 8];
      end
      if (sel && req.rd) begin
        lane_rdata[i*8 +: 8] <= mem[entry];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel && req.rd) begin
      rd_odd <= odd_word;
    end
  end

  assign rdata = rd_odd ? {8'h00, lane_rdata[23:16]} : lane_rdata[15:0];

  a_entry_in_range: assert property (
    @(posedge clk) sel |-> (pal_offset[INT_ADDR_W-1:1] < (INT_ADDR_W-1)'(PAL_ENTRIES))
  );

endmodule

//--- control_regs.sv
// --------------------
// Only SYS_CTRL and MEM_BANK are writable. MEM_BANK keeps its low byte.
// --------------------
`timescale 1ns/100ps

module control_regs import video_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  mpu_req_t              req,
  input  logic                  sel,
  input  disp_status_t          status,
  output logic [MPU_DATA_W-1:0] rdata,
  output logic [BANK_W-1:0]     bank,
  output logic                  vram_grant
);

  reg_index_e            index;
  logic [MPU_DATA_W-1:0] sys_ctrl;
  logic [BANK_W-1:0]     mem_bank;
  logic [MPU_DATA_W-1:0] read_value;

  assign index = reg_index_e'(req.addr[3:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      sys_ctrl <= '0;
      mem_bank <= '0;
    end else if (sel && req.wr) begin
      case (index)
        SYS_CTRL: begin
          if (req.be[0]) sys_ctrl[7:0]  <= req.data[7:0];
          if (req.be[1]) sys_ctrl[15:8] <= req.data[15:8];
        end
        MEM_BANK: begin
          if (req.be[0]) mem_bank <= req.data[BANK_W-1:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (index)
      ID:            read_value = ID_VALUE;
      SYS_CTRL:      read_value = sys_ctrl;
      MEM_BANK:      read_value = {{(MPU_DATA_W-BANK_W){1'b0}}, mem_bank};
      OUTPUT_STATUS: read_value = {12'h000, status.vblank, status.hblank,
                                   status.vsync, status.hsync};
      SCAN_X:        read_value = {{(MPU_DATA_W-SCAN_W){1'b0}}, status.scan_x};
      SCAN_Y:        read_value = {{(MPU_DATA_W-SCAN_W){1'b0}}, status.scan_y};
      default:       read_value = '0;
    endcase
  end

  // Status is captured in the strobe cycle itself
  always_ff @(posedge clk) begin
    if (sel && req.rd) begin
      rdata <= read_value;
    end
  end

  assign bank       = mem_bank;
  assign vram_grant = sys_ctrl[SYS_CTRL_VRAM_ACCESS];

  // Decoder must never select this block outside its window
  a_sel_in_window: assert property (
    @(posedge clk) disable iff (rst)
    sel |-> in_window(req.addr, REG_BASE, INT_ADDR_W'(NUM_REGS))
  );

endmodule

//--- mpu_bus_decoder.sv
// --------------------
// Page 0 is fixed; pages 1-15 map through the bank register.
// Read data appears the cycle after the strobe, zero otherwise.
// --------------------
`timescale 1ns/100ps

module mpu_bus_decoder import video_core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mpu_en,
  input  logic                  mpu_rd,
  input  logic                  mpu_wr,
  input  logic [1:0]            mpu_be,
  input  logic [MPU_ADDR_W-1:0] mpu_addr,
  input  logic [MPU_DATA_W-1:0] mpu_data_in,
  input  logic [BANK_W-1:0]     bank,
  input  logic                  vram_grant,
  input  logic [MPU_DATA_W-1:0] reg_rdata,
  input  logic [MPU_DATA_W-1:0] pal_rdata,
  input  logic [MPU_DATA_W-1:0] vram_data_in,
  output mpu_req_t              req,
  output logic                  reg_sel,
  output logic                  pal_sel,
  output vram_bus_t             vram,
  output logic [MPU_DATA_W-1:0] mpu_data_out
);

  logic [PAGE_OFFSET_W-1:0]          page_offset;
  logic [MPU_ADDR_W-PAGE_OFFSET_W-1:0] page_index;
  logic [INT_ADDR_W-1:0]             int_addr;
  logic [INT_ADDR_W-1:0]             vram_offset;
  region_e                           region;
  logic                              strobe;
  logic                              vram_hit;

  // Read-back state for the access issued last cycle
  region_e                           rd_region;
  logic                              rd_valid;
  logic                              rd_low;
  logic [MPU_DATA_W-1:0]             low_data;
  logic [MPU_DATA_W-1:0]             high_data;

  assign page_offset = mpu_addr[PAGE_OFFSET_W-1:0];
  assign page_index  = mpu_addr[MPU_ADDR_W-1:PAGE_OFFSET_W];
  assign int_addr    = (page_index == '0) ? {{BANK_W{1'b0}}, page_offset}
                                          : {bank, page_offset};

  always_comb begin
    region = REGION_NONE;
    if (in_window(int_addr, REG_BASE, INT_ADDR_W'(NUM_REGS))) begin
      region = REGION_REGS;
    end else if (in_window(int_addr, PAL_BASE, PAL_LEN)) begin
      region = REGION_PAL;
    end else if (in_window(int_addr, VRAM_BASE, VRAM_LEN)) begin
      region = REGION_VRAM;
    end
  end

  assign strobe = mpu_en & (mpu_rd | mpu_wr);

  assign req.rd   = mpu_en & mpu_rd;
  assign req.wr   = mpu_en & mpu_wr;
  assign req.be   = mpu_be;
  assign req.addr = int_addr;
  assign req.data = mpu_data_in;

  assign reg_sel = mpu_en & (region == REGION_REGS);
  assign pal_sel = mpu_en & (region == REGION_PAL);

  // VRAM traffic only while the MPU owns the bus
  assign vram_hit    = strobe & vram_grant & (region == REGION_VRAM);
  assign vram_offset = int_addr - VRAM_BASE;

  assign vram.en   = vram_hit;
  assign vram.rd   = vram_hit & mpu_rd;
  assign vram.wr   = vram_hit & mpu_wr;
  assign vram.be   = mpu_be;
  assign vram.addr = vram_offset[VRAM_ADDR_W-1:0];
  assign vram.data = mpu_data_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid  <= 1'b0;
      rd_region <= REGION_NONE;
      rd_low    <= 1'b0;
    end else begin
      rd_valid  <= mpu_en & mpu_rd;
      rd_region <= region;
      rd_low    <= int_addr < LOW_MEM_SIZE;
    end
  end

  // Split mux keeps the low and high memory paths short
  assign low_data = (rd_region == REGION_REGS) ? reg_rdata :
                    (rd_region == REGION_PAL)  ? pal_rdata : UNMAPPED_VALUE;

  // A VRAM read without the grant still returns whatever VRAM drives
  assign high_data = (rd_region == REGION_VRAM) ? vram_data_in : UNMAPPED_VALUE;

  assign mpu_data_out = !rd_valid ? '0 : (rd_low ? low_data : high_data);

  a_rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(req.rd && req.wr)
  );

endmodule

//--- video_core.sv
// --------------------
// Sync outputs are active high. The VRAM bus is idle unless the MPU holds
// the grant bit in SYS_CTRL.
// --------------------
`timescale 1ns/100ps

module video_core import video_core_pkg::*; #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic                   clk,
  input  logic                   rst,
  // MPU bus
  input  logic                   mpu_en,
  input  logic                   mpu_rd,
  input  logic                   mpu_wr,
  input  logic [1:0]             mpu_be,
  input  logic [MPU_ADDR_W-1:0]  mpu_addr,
  input  logic [MPU_DATA_W-1:0]  mpu_data_in,
  output logic [MPU_DATA_W-1:0]  mpu_data_out,
  // External VRAM
  output logic                   vram_en,
  output logic                   vram_rd,
  output logic                   vram_wr,
  output logic [1:0]             vram_be,
  output logic [VRAM_ADDR_W-1:0] vram_addr,
  input  logic [MPU_DATA_W-1:0]  vram_data_in,
  output logic [MPU_DATA_W-1:0]  vram_data_out,
  // Display sync
  output logic                   vga_hsync,
  output logic                   vga_vsync
);

  mpu_req_t              req;
  vram_bus_t             vram;
  disp_status_t          status;
  logic                  reg_sel;
  logic                  pal_sel;
  logic [MPU_DATA_W-1:0] reg_rdata;
  logic [MPU_DATA_W-1:0] pal_rdata;
  logic [BANK_W-1:0]     bank;
  logic                  vram_grant;

  mpu_bus_decoder u_decoder (
    .clk          (clk),
    .rst          (rst),
    .mpu_en       (mpu_en),
    .mpu_rd       (mpu_rd),
    .mpu_wr       (mpu_wr),
    .mpu_be       (mpu_be),
    .mpu_addr     (mpu_addr),
    .mpu_data_in  (mpu_data_in),
    .bank         (bank),
    .vram_grant   (vram_grant),
    .reg_rdata    (reg_rdata),
    .pal_rdata    (pal_rdata),
    .vram_data_in (vram_data_in),
    .req          (req),
    .reg_sel      (reg_sel),
    .pal_sel      (pal_sel),
    .vram         (vram),
    .mpu_data_out (mpu_data_out)
  );

  control_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .sel        (reg_sel),
    .status     (status),
    .rdata      (reg_rdata),
    .bank       (bank),
    .vram_grant (vram_grant)
  );

  palette_ram u_palette (
    .clk   (clk),
    .req   (req),
    .sel   (pal_sel),
    .rdata (pal_rdata)
  );

  display_timing #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) u_timing (
    .clk    (clk),
    .rst    (rst),
    .status (status)
  );

  assign vram_en       = vram.en;
  assign vram_rd       = vram.rd;
  assign vram_wr       = vram.wr;
  assign vram_be       = vram.be;
  assign vram_addr     = vram.addr;
  assign vram_data_out = vram.data;
  assign vga_hsync     = status.hsync;
  assign vga_vsync     = status.vsync;

endmodule

//--- tb_video_core.sv
// --------------------
// Needs video_core_patterns.txt in the working directory (project root).
// Small timing parameters give a 24 x 12 cycle frame.
// --------------------
`timescale 1ns/100ps

module tb_video_core;

  localparam int H_VISIBLE = 16;
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 4;
  localparam int H_BACK    = 2;
  localparam int V_VISIBLE = 8;
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 1;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // Op codes in the first column of the pattern file
  localparam logic [3:0] OP_WRITE   = 4'h0;
  localparam logic [3:0] OP_READ    = 4'h1;
  localparam logic [3:0] OP_IDLE    = 4'h2;
  localparam logic [3:0] OP_STATUS  = 4'h3;
  localparam logic [3:0] OP_VRAM_WR = 4'h4;
  localparam logic [3:0] OP_VRAM_RD = 4'h5;

  typedef struct packed {
    logic [127:0] name;
    logic [3:0]   op;
    logic [15:0]  addr;
    logic [1:0]   be;
    logic [15:0]  data;
    logic [15:0]  expected;
  } pattern_t;

  logic         clk = 1'b0;
  logic         rst;
  logic         mpu_en;
  logic         mpu_rd;
  logic         mpu_wr;
  logic [1:0]   mpu_be;
  logic [15:0]  mpu_addr;
  logic [15:0]  mpu_data_in;
  logic [15:0]  mpu_data_out;
  logic         vram_en;
  logic         vram_rd;
  logic         vram_wr;
  logic [1:0]   vram_be;
  logic [15:0]  vram_addr;
  logic [15:0]  vram_data_in = '0;
  logic [15:0]  vram_data_out;
  logic         vga_hsync;
  logic         vga_vsync;

  logic [15:0]  vram_mem [65536];
  pattern_t     patterns [$];
  int unsigned  scan_cycle  = 0;
  int unsigned  run_cycles  = 0;
  int unsigned  cycle_limit = 0;
  logic         timing_live = 1'b0;
  logic         pend_valid;
  logic [15:0]  pend_exp;
  logic [127:0] pend_name;
  int           read_errors;
  int           bus_errors;
  int           file_errors;
  int           sync_errors = 0;

  always #2 clk = ~clk;

  video_core #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .mpu_en        (mpu_en),
    .mpu_rd        (mpu_rd),
    .mpu_wr        (mpu_wr),
    .mpu_be        (mpu_be),
    .mpu_addr      (mpu_addr),
    .mpu_data_in   (mpu_data_in),
    .mpu_data_out  (mpu_data_out),
    .vram_en       (vram_en),
    .vram_rd       (vram_rd),
    .vram_wr       (vram_wr),
    .vram_be       (vram_be),
    .vram_addr     (vram_addr),
    .vram_data_in  (vram_data_in),
    .vram_data_out (vram_data_out),
    .vga_hsync     (vga_hsync),
    .vga_vsync     (vga_vsync)
  );

  // External VRAM model answering one cycle after the strobe
  always @(posedge clk) begin
    if (vram_en && vram_wr && vram_be[0]) begin
      vram_mem[vram_addr][7:0] <= vram_data_out[7:0];
    end
    if (vram_en && vram_wr && vram_be[1]) begin
      vram_mem[vram_addr][15:8] <= vram_data_out[15:8];
    end
    if (vram_en && vram_rd) begin
      vram_data_in <= vram_mem[vram_addr];
    end
  end

  // Scan position counts clocks since reset release
  always @(posedge clk) begin
    timing_live <= 1'b1;
    run_cycles  <= run_cycles + 1;
    if (rst) begin
      scan_cycle <= 0;
    end else begin
      scan_cycle <= scan_cycle + 1;
    end
    if (cycle_limit != 0 && run_cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Register value the timing rules give for a scan cycle
  function automatic logic [15:0] expected_status(input logic [3:0] index,
                                                  input int unsigned cyc);
    int unsigned h;
    int unsigned v;
    logic        hb;
    logic        vb;
    logic        hs;
    logic        vs;
    h  = cyc % H_TOTAL;
    v  = (cyc / H_TOTAL) % V_TOTAL;
    hb = h >= H_VISIBLE;
    vb = v >= V_VISIBLE;
    hs = (h >= H_VISIBLE + H_FRONT) && (h < H_VISIBLE + H_FRONT + H_SYNC);
    vs = (v >= V_VISIBLE + V_FRONT) && (v < V_VISIBLE + V_FRONT + V_SYNC);
    case (index)
      4'd3:    return {12'h000, vb, hb, vs, hs};
      4'd4:    return hb ? 16'h0000 : 16'(h);
      4'd5:    return vb ? 16'h0000 : 16'(v);
      default: return 16'h0000;
    endcase
  endfunction

  always @(negedge clk) begin : sync_check
    logic [15:0] st;
    if (timing_live) begin
      st = expected_status(4'd3, scan_cycle);
      assert (vga_hsync == st[0] && vga_vsync == st[1]) else begin
        sync_errors++;
        $display("ERR sync_cycle_%0d: expected %b%b, actual %b%b", scan_cycle,
                 st[1], st[0], vga_vsync, vga_hsync);
      end
    end
  end

  task automatic load_patterns();
    int           fd;
    int           count;
    string        line;
    logic [3:0]   op;
    logic [127:0] name;
    logic [15:0]  addr;
    logic [1:0]   be;
    logic [15:0]  data;
    logic [15:0]  expected;
    pattern_t     p;
    fd = $fopen("video_core_patterns.txt", "r");
    if (fd == 0) begin
      file_errors++;
      $display("Could not open the pattern file video_core_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          count = $sscanf(line, "%h %s %h %h %h %h", op, name, addr, be, data, expected);
          if (count == 6) begin
            p.name     = name;
            p.op       = op;
            p.addr     = addr;
            p.be       = be;
            p.data     = data;
            p.expected = expected;
            patterns.push_back(p);
          end else begin
            file_errors++;
            $display("Pattern line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_bus(input logic en, input logic rd, input logic wr, input pattern_t p);
    mpu_en      = en;
    mpu_rd      = rd;
    mpu_wr      = wr;
    mpu_be      = p.be;
    mpu_addr    = p.addr;
    mpu_data_in = p.data;
  endtask

  // Sampled mid low phase where the combinational VRAM pins have settled
  task automatic check_vram_pins(input pattern_t p, input logic rd, input logic wr,
                                 input logic [15:0] vaddr);
    #1;
    if (!rd && !wr) begin
      assert (!vram_en && !vram_rd && !vram_wr) else begin
        bus_errors++;
        $display("%0s: VRAM bus is active but should be idle", p.name);
      end
    end else begin
      assert (vram_en && vram_rd == rd && vram_wr == wr && vram_be == p.be) else begin
        bus_errors++;
        $display("ERR %0s: expected en rd wr be %b%b%b%b, actual %b%b%b%b", p.name,
                 1'b1, rd, wr, p.be, vram_en, vram_rd, vram_wr, vram_be);
      end
      assert (vram_addr == vaddr) else begin
        bus_errors++;
        $display("ERR %0s: expected %h, actual %h", p.name, vaddr, vram_addr);
      end
      assert (!wr || vram_data_out == p.data) else begin
        bus_errors++;
        $display("ERR %0s: expected %h, actual %h", p.name, p.data, vram_data_out);
      end
    end
  endtask

  // The falling edge ends the drive period, and a read issued in it is due
  task automatic close_cycle();
    @(negedge clk);
    if (pend_valid) begin
      assert (mpu_data_out == pend_exp) else begin
        read_errors++;
        $display("ERR %0s: expected %h, actual %h", pend_name, pend_exp, mpu_data_out);
      end
    end else begin
      assert (mpu_data_out == 16'h0000) else begin
        read_errors++;
        $display("mpu_data_out is %h although no read was issued", mpu_data_out);
      end
    end
    pend_valid = 1'b0;
  endtask

  task automatic expect_read(input pattern_t p, input logic [15:0] value);
    pend_valid = 1'b1;
    pend_exp   = value;
    pend_name  = p.name;
  endtask

  task automatic run_op(input pattern_t p);
    case (p.op)
      OP_WRITE: begin
        drive_bus(1'b1, 1'b0, 1'b1, p);
        check_vram_pins(p, 1'b0, 1'b0, 16'h0000);
      end
      OP_READ: begin
        drive_bus(1'b1, 1'b1, 1'b0, p);
        expect_read(p, p.expected);
        check_vram_pins(p, 1'b0, 1'b0, 16'h0000);
      end
      OP_STATUS: begin
        drive_bus(1'b1, 1'b1, 1'b0, p);
        expect_read(p, expected_status(p.addr[3:0], scan_cycle));
        check_vram_pins(p, 1'b0, 1'b0, 16'h0000);
      end
      OP_VRAM_WR: begin
        drive_bus(1'b1, 1'b0, 1'b1, p);
        check_vram_pins(p, 1'b0, 1'b1, p.expected);
      end
      OP_VRAM_RD: begin
        drive_bus(1'b1, 1'b1, 1'b0, p);
        expect_read(p, p.expected);
        check_vram_pins(p, 1'b1, 1'b0, p.data);
      end
      OP_IDLE: begin
        drive_bus(1'b0, 1'b0, 1'b0, p);
        for (int n = 1; n < int'(p.data); n++) begin
          check_vram_pins(p, 1'b0, 1'b0, 16'h0000);
          close_cycle();
        end
        check_vram_pins(p, 1'b0, 1'b0, 16'h0000);
      end
      default: begin
        file_errors++;
        $display("%0s: unknown op code %h in the pattern file", p.name, p.op);
      end
    endcase
    close_cycle();
  endtask

  initial begin
    int unsigned op_cycles;
    rst         = 1'b1;
    mpu_en      = 1'b0;
    mpu_rd      = 1'b0;
    mpu_wr      = 1'b0;
    mpu_be      = 2'b00;
    mpu_addr    = 16'h0000;
    mpu_data_in = 16'h0000;
    read_errors = 0;
    bus_errors  = 0;
    file_errors = 0;
    pend_valid  = 1'b0;
    pend_exp    = 16'h0000;
    pend_name   = '0;
    load_patterns();
    op_cycles = 0;
    foreach (patterns[i]) begin
      if (patterns[i].op == OP_IDLE) begin
        op_cycles += patterns[i].data;
      end else begin
        op_cycles += 1;
      end
    end
    cycle_limit = op_cycles + 2 * H_TOTAL * V_TOTAL;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (patterns[i]) begin
      run_op(patterns[i]);
    end
    $display("Summary: %0d patterns, errors %0d read, %0d bus, %0d sync, %0d file",
             patterns.size(), read_errors, bus_errors, sync_errors, file_errors);
    if (read_errors + bus_errors + sync_errors + file_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- video_core_patterns.txt
# Columns: op name addr be data expected, all hex except name
# op 0 wr, 1 rd, 2 idle (data = cycles), 3 status rd, 4 VRAM wr (expected = VRAM addr), 5 VRAM rd (data = VRAM addr)
2 reset_idle      0000 0 0003 0000
1 id_read         0000 3 0000 4443
1 unused_reg7     0007 3 0000 0000
1 unused_reg15    000F 3 0000 0000
1 unmapped_page0  0100 3 0000 DEAD
0 id_write        0000 3 FFFF 0000
1 id_after_write  0000 3 0000 4443
0 sysctrl_hi      0001 2 ABCD 0000
1 sysctrl_hi_rd   0001 3 0000 AB00
0 sysctrl_lo      0001 1 5678 0000
1 sysctrl_lo_rd   0001 3 0000 AB78
0 bank_hi_only    0002 2 1234 0000
1 bank_hi_rd      0002 3 0000 0000
0 bank_set_05     0002 3 9905 0000
1 bank_05_rd      0002 3 0000 0005
1 unmapped_bank   1000 3 0000 DEAD
0 bank_set_12     0002 1 0012 0000
1 bank_12_rd      0002 3 0000 0012
0 vram_no_grant   1034 3 7777 0000
1 vram_rd_nogrant 1034 3 0000 0000
0 pal_even_wr     080A 3 1122 0000
1 pal_even_rd     080A 3 0000 1122
0 pal_even_lo     080A 1 44AA 0000
1 pal_even_lo_rd  080A 3 0000 11AA
0 pal_odd_wr      080B 3 5566 0000
1 pal_odd_rd      080B 3 0000 0066
0 pal_odd_hi      080B 2 7788 0000
1 pal_odd_hi_rd   080B 3 0000 0066
0 grant_on        0001 1 0001 0000
1 grant_rd        0001 3 0000 AB01
4 vram_wr_a       1034 3 BEEF 2034
4 vram_wr_b       1035 3 0123 2035
4 vram_wr_c       1FFF 3 4567 2FFF
4 vram_wr_a_hi    1034 2 5500 2034
5 vram_rd_c       1FFF 3 2FFF 4567
5 vram_rd_a       1034 3 2034 55EF
5 vram_rd_b       1035 3 2035 0123
3 status_a        0003 3 0000 0000
3 scan_x_a        0004 3 0000 0000
3 scan_y_a        0005 3 0000 0000
2 frame_idle      0000 0 0130 0000
3 status_b        0003 3 0000 0000
3 scan_x_b        0004 3 0000 0000
3 scan_y_b        0005 3 0000 0000
2 short_idle      0000 0 0007 0000
3 status_c        0003 3 0000 0000
3 scan_x_c        0004 3 0000 0000
3 scan_y_c        0005 3 0000 0000

//--- all.f
video_core_pkg.sv
display_timing.sv
palette_ram.sv
control_regs.sv
mpu_bus_decoder.sv
video_core.sv
tb_video_core.sv

//--- Makefile
# Verilator flow, run from the project root
VERILATOR  ?= verilator
TB_TOP     ?= tb_video_core
RTL_TOP    ?= video_core
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
